/* src/mem_arb_defs.svh */
/*
 * Memory arbiter shared definitions
 * Widths of the cache request and response words, the QoS level
 * width and the transaction ID owned by the instruction cache
 */

`ifndef MEM_ARB_DEFS_SVH
`define MEM_ARB_DEFS_SVH

// Address and data widths of the memory port
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// Transaction ID carried by every request and its response
`define MEM_ID_W 4

// QoS priority level, 0 is the lowest
`define QOS_LEVEL_W 3

// Responses with this ID go to the instruction cache, all others to data
`define ICACHE_ID 0

`endif

/* src/mem_arb_pkg.sv */
/*
 * Memory arbiter types
 * Cache request and response words, the per-request QoS word and
 * the combined word carried from the arbiter through the buffer
 */

`include "mem_arb_defs.svh"

package mem_arb_pkg;

    // Request issued by a cache toward the next memory level
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0]   addr;
        logic [`MEM_DATA_W-1:0]   wdata;
        // One strobe bit per data byte
        logic [`MEM_DATA_W/8-1:0] be;
        logic                     we;
        logic [`MEM_ID_W-1:0]     id;
    } memory_req_t;

    // Response returned by memory, routed by id
    typedef struct packed {
        logic [`MEM_DATA_W-1:0] rdata;
        logic [`MEM_ID_W-1:0]   id;
        logic                   err;
    } memory_rsp_t;

    // Per-request priority information
    typedef struct packed {
        logic [`QOS_LEVEL_W-1:0] qos_level;
        logic                    urgent;
    } qos_config_t;

    // Granted request together with the QoS word that travels with it
    typedef struct packed {
        memory_req_t req;
        qos_config_t qos;
    } arb_req_t;

endpackage : mem_arb_pkg

/* src/qos_arbiter.sv */
/*
 * QoS arbiter, stage one of the memory request path
 * Picks the instruction or data cache request each cycle by QoS level
 * and urgency, or gives the instruction cache fixed priority when QoS
 * is off. The grant is held while the downstream buffer stalls.
 */

`timescale 1ns/1ps

module qos_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // Instruction cache request side
    input  logic                     icache_req_valid_i,
    input  mem_arb_pkg::memory_req_t icache_req_i,
    input  mem_arb_pkg::qos_config_t icache_qos_i,
    output logic                     icache_req_ready_o,

    // Data cache request side
    input  logic                     dcache_req_valid_i,
    input  mem_arb_pkg::memory_req_t dcache_req_i,
    input  mem_arb_pkg::qos_config_t dcache_qos_i,
    output logic                     dcache_req_ready_o,

    input  logic                     qos_enable_i,

    // Toward the request buffer
    output logic                     out_valid_o,
    output mem_arb_pkg::arb_req_t    out_req_o,
    input  logic                     out_ready_i
);

    import mem_arb_pkg::*;

    logic        any_valid;
    logic        pick_icache;
    logic        grant_icache;
    logic        locked_q;
    logic        lock_icache_q;
    qos_config_t win_qos;

    // ==================================================================
    // Combinational pick
    // ==================================================================

    always_comb begin : proc_pick
        pick_icache = 1'b0;
        if (icache_req_valid_i && dcache_req_valid_i) begin
            if (!qos_enable_i) begin
                // Fixed priority fallback
                pick_icache = 1'b1;
            end else if (icache_qos_i.qos_level > dcache_qos_i.qos_level) begin
                pick_icache = 1'b1;
            end else if (icache_qos_i.qos_level == dcache_qos_i.qos_level) begin
                // Tie on level, urgency decides
                pick_icache = icache_qos_i.urgent && !dcache_qos_i.urgent;
            end
            // Data cache wins the remaining cases
        end else begin
            // Lone requester, or nobody
            pick_icache = icache_req_valid_i;
        end
    end

    // ==================================================================
    // Grant lock
    // ==================================================================

    // Stalled handshake keeps last cycle's winner
    assign grant_icache = locked_q ? lock_icache_q : pick_icache;

    always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_lock
        if (!rst_n_i) begin
            locked_q      <= 1'b0;
            lock_icache_q <= 1'b0;
        end else begin
            locked_q      <= out_valid_o && !out_ready_i;
            lock_icache_q <= grant_icache;
        end
    end

    // ==================================================================
    // Output mux and readys
    // ==================================================================

    assign any_valid   = icache_req_valid_i || dcache_req_valid_i;
    assign out_valid_o = grant_icache ? icache_req_valid_i : dcache_req_valid_i;
    assign win_qos     = grant_icache ? icache_qos_i : dcache_qos_i;

    always_comb begin : proc_out_req
        out_req_o.req = grant_icache ? icache_req_i : dcache_req_i;
        // Zero QoS goes downstream when QoS is off
        out_req_o.qos = qos_enable_i ? win_qos : '0;
    end

    // Loser is blocked; with no request both follow the buffer's ready
    assign icache_req_ready_o = out_ready_i && (grant_icache || !any_valid);
    assign dcache_req_ready_o = out_ready_i && (!grant_icache || !any_valid);

endmodule : qos_arbiter

/* src/req_pipe_stage.sv */
/*
 * Request buffer, stage two of the memory request path
 * Two-entry in-order buffer between the arbiter and memory with
 * registered output and a registered input ready
 */

`timescale 1ns/1ps

module req_pipe_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // From the arbiter
    input  logic                  in_valid_i,
    input  mem_arb_pkg::arb_req_t in_req_i,
    output logic                  in_ready_o,

    // Toward memory
    output logic                  out_valid_o,
    output mem_arb_pkg::arb_req_t out_req_o,
    input  logic                  out_ready_i
);

    import mem_arb_pkg::*;

    // Entry storage
    arb_req_t   slot_q [0:1];

    // Ring pointers and fill level
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic [1:0] count_d;
    logic       in_ready_q;

    logic       push;
    logic       pop;

    // ==================================================================
    // Handshakes
    // ==================================================================

    assign push = in_valid_i && in_ready_q;
    assign pop  = out_valid_o && out_ready_i;

    assign count_d = count_q + 2'(push) - 2'(pop);

    // Head entry drives memory straight from the slot registers
    assign out_valid_o = (count_q != 2'd0);
    assign out_req_o   = slot_q[rd_ptr_q];

    // Ready only depends on state, memory ready never reaches the caches
    assign in_ready_o  = in_ready_q;

    // ==================================================================
    // State
    // ==================================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_ctrl
        if (!rst_n_i) begin
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
            count_q    <= 2'd0;
            in_ready_q <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q    <= count_d;
            // Drop ready once both entries hold a request
            in_ready_q <= (count_d != 2'd2);
        end
    end

    always_ff @(posedge clk_i) begin : proc_slots
        if (push) begin
            slot_q[wr_ptr_q] <= in_req_i;
        end
    end

endmodule : req_pipe_stage

/* src/rsp_router.sv */
/*
 * Response router, stage three
 * Steers each memory response to the cache that owns its ID and
 * returns that cache's ready to memory, with no added latency
 */

`timescale 1ns/1ps

`include "mem_arb_defs.svh"

module rsp_router (
    // From memory
    input  logic                     mem_rsp_valid_i,
    input  mem_arb_pkg::memory_rsp_t mem_rsp_i,
    output logic                     mem_rsp_ready_o,

    // Toward the caches
    output logic                     icache_rsp_valid_o,
    output logic                     dcache_rsp_valid_o,
    output mem_arb_pkg::memory_rsp_t rsp_o,
    input  logic                     icache_rsp_ready_i,
    input  logic                     dcache_rsp_ready_i
);

    // Instruction cache ID at the width of the ID field
    localparam logic [`MEM_ID_W-1:0] ICACHE_ID_VAL = `ICACHE_ID;

    logic is_icache;

    // ==================================================================
    // Ownership decode
    // ==================================================================

    // Any ID other than the instruction cache's belongs to data
    assign is_icache = (mem_rsp_i.id == ICACHE_ID_VAL);

    // Only the owner sees valid
    assign icache_rsp_valid_o = mem_rsp_valid_i && is_icache;
    assign dcache_rsp_valid_o = mem_rsp_valid_i && !is_icache;

    // Payload is shared, the valids pick the receiver
    assign rsp_o = mem_rsp_i;

    // ==================================================================
    // Back-pressure
    // ==================================================================

    always_comb begin : proc_rsp_ready
        if (!mem_rsp_valid_i) begin
            // Idle bus, memory may present a response at any time
            mem_rsp_ready_o = 1'b1;
        end else if (is_icache) begin
            mem_rsp_ready_o = icache_rsp_ready_i;
        end else begin
            mem_rsp_ready_o = dcache_rsp_ready_i;
        end
    end

endmodule : rsp_router

/* src/mem_arb_top.sv */
/*
 * Memory request arbiter top
 * QoS arbiter, two-entry request buffer and response router between
 * the instruction and data caches and the next memory level
 */

`timescale 1ns/1ps

module mem_arb_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // Instruction cache
    input  logic                     icache_req_valid_i,
    input  mem_arb_pkg::memory_req_t icache_req_i,
    input  mem_arb_pkg::qos_config_t icache_qos_i,
    output logic                     icache_req_ready_o,
    output logic                     icache_rsp_valid_o,
    input  logic                     icache_rsp_ready_i,

    // Data cache
    input  logic                     dcache_req_valid_i,
    input  mem_arb_pkg::memory_req_t dcache_req_i,
    input  mem_arb_pkg::qos_config_t dcache_qos_i,
    output logic                     dcache_req_ready_o,
    output logic                     dcache_rsp_valid_o,
    input  logic                     dcache_rsp_ready_i,

    // Response payload shared by both caches
    output mem_arb_pkg::memory_rsp_t cache_rsp_o,

    input  logic                     qos_enable_i,

    // Next memory level
    output logic                     mem_req_valid_o,
    output mem_arb_pkg::memory_req_t mem_req_o,
    output mem_arb_pkg::qos_config_t mem_qos_config_o,
    input  logic                     mem_req_ready_i,
    input  logic                     mem_rsp_valid_i,
    input  mem_arb_pkg::memory_rsp_t mem_rsp_i,
    output logic                     mem_rsp_ready_o
);

    import mem_arb_pkg::*;

    // Arbiter to buffer
    logic     arb_valid;
    logic     arb_ready;
    arb_req_t arb_req;

    // Buffer head toward memory
    arb_req_t buf_req;

    // ==================================================================
    // Request path
    // ==================================================================

    qos_arbiter u_qos_arbiter (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .icache_req_valid_i (icache_req_valid_i),
        .icache_req_i       (icache_req_i),
        .icache_qos_i       (icache_qos_i),
        .icache_req_ready_o (icache_req_ready_o),
        .dcache_req_valid_i (dcache_req_valid_i),
        .dcache_req_i       (dcache_req_i),
        .dcache_qos_i       (dcache_qos_i),
        .dcache_req_ready_o (dcache_req_ready_o),
        .qos_enable_i       (qos_enable_i),
        .out_valid_o        (arb_valid),
        .out_req_o          (arb_req),
        .out_ready_i        (arb_ready)
    );

    req_pipe_stage u_req_pipe_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (arb_valid),
        .in_req_i    (arb_req),
        .in_ready_o  (arb_ready),
        .out_valid_o (mem_req_valid_o),
        .out_req_o   (buf_req),
        .out_ready_i (mem_req_ready_i)
    );

    // Memory sees request and QoS as separate ports
    assign mem_req_o        = buf_req.req;
    assign mem_qos_config_o = buf_req.qos;

    // ==================================================================
    // Response path
    // ==================================================================

    rsp_router u_rsp_router (
        .mem_rsp_valid_i    (mem_rsp_valid_i),
        .mem_rsp_i          (mem_rsp_i),
        .mem_rsp_ready_o    (mem_rsp_ready_o),
        .icache_rsp_valid_o (icache_rsp_valid_o),
        .dcache_rsp_valid_o (dcache_rsp_valid_o),
        .rsp_o              (cache_rsp_o),
        .icache_rsp_ready_i (icache_rsp_ready_i),
        .dcache_rsp_ready_i (dcache_rsp_ready_i)
    );

endmodule : mem_arb_top

/* test/tb_clkgen.sv */
/*
 * Testbench clock and reset source
 * Free-running clock and an active-low reset held for a few cycles
 */

`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the DUT's sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clkgen

/* test/mem_arb_asserts.sv */
/*
 * Memory arbiter assertions
 * Handshake payload stability and one-hot response routing
 */

`timescale 1ns/1ps

module mem_arb_asserts (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic                     icache_req_valid_i,
    input logic                     icache_req_ready_o,
    input mem_arb_pkg::memory_req_t icache_req_i,
    input logic                     dcache_req_valid_i,
    input logic                     dcache_req_ready_o,
    input mem_arb_pkg::memory_req_t dcache_req_i,
    input logic                     mem_req_valid_o,
    input logic                     mem_req_ready_i,
    input mem_arb_pkg::memory_req_t mem_req_o,
    input logic                     icache_rsp_valid_o,
    input logic                     dcache_rsp_valid_o
);

    // Stalled requests keep valid and payload
    a_icache_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        icache_req_valid_i && !icache_req_ready_o |=>
            icache_req_valid_i && $stable(icache_req_i))
        else $error("icache request changed while stalled");

    a_dcache_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dcache_req_valid_i && !dcache_req_ready_o |=>
            dcache_req_valid_i && $stable(dcache_req_i))
        else $error("dcache request changed while stalled");

    // Memory side, the buffer head must hold too
    a_mem_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_valid_o && !mem_req_ready_i |=>
            mem_req_valid_o && $stable(mem_req_o))
        else $error("memory request changed while stalled");

    // Response owned by one cache only
    a_rsp_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(icache_rsp_valid_o && dcache_rsp_valid_o))
        else $error("both response valids high");

    a_rsp_reset : assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !icache_rsp_valid_o && !dcache_rsp_valid_o)
        else $error("response valid high after reset");

endmodule : mem_arb_asserts

bind mem_arb_top mem_arb_asserts u_mem_arb_asserts (.*);

/* test/mem_arb_tb.sv */
/*
 * Memory arbiter testbench
 * Directed tests for arbitration, buffering, back-pressure and
 * response routing, with a recording memory model and a watchdog
 */

`timescale 1ns/1ps

`include "mem_arb_defs.svh"

module mem_arb_tb;

    import mem_arb_pkg::*;

    // Tests take about 2 us, ten times that for margin
    localparam int WATCHDOG_NS = 20000;
    localparam int MAX_WAIT    = 50;

    logic        clk;
    logic        rst_n;
    logic        icache_req_valid, dcache_req_valid;
    memory_req_t icache_req, dcache_req;
    qos_config_t icache_qos, dcache_qos;
    logic        icache_req_ready, dcache_req_ready;
    logic        icache_rsp_valid, dcache_rsp_valid;
    logic        icache_rsp_ready, dcache_rsp_ready;
    memory_rsp_t cache_rsp;
    logic        qos_enable;
    logic        mem_req_valid, mem_req_ready;
    memory_req_t mem_req;
    qos_config_t mem_qos;
    logic        mem_rsp_valid, mem_rsp_ready;
    memory_rsp_t mem_rsp;

    int          error_count = 0;
    int          check_count = 0;
    // Requests accepted by memory, in acceptance order
    arb_req_t    seen_q[$];

    tb_clkgen #(.PERIOD_NS(8.0), .RESET_CYCLES(4)) u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mem_arb_top UUT (
        .clk_i (clk), .rst_n_i (rst_n),
        .icache_req_valid_i (icache_req_valid), .icache_req_i (icache_req),
        .icache_qos_i (icache_qos), .icache_req_ready_o (icache_req_ready),
        .icache_rsp_valid_o (icache_rsp_valid), .icache_rsp_ready_i (icache_rsp_ready),
        .dcache_req_valid_i (dcache_req_valid), .dcache_req_i (dcache_req),
        .dcache_qos_i (dcache_qos), .dcache_req_ready_o (dcache_req_ready),
        .dcache_rsp_valid_o (dcache_rsp_valid), .dcache_rsp_ready_i (dcache_rsp_ready),
        .cache_rsp_o (cache_rsp), .qos_enable_i (qos_enable),
        .mem_req_valid_o (mem_req_valid), .mem_req_o (mem_req),
        .mem_qos_config_o (mem_qos), .mem_req_ready_i (mem_req_ready),
        .mem_rsp_valid_i (mem_rsp_valid), .mem_rsp_i (mem_rsp),
        .mem_rsp_ready_o (mem_rsp_ready)
    );

    // ==================================================================
    // Memory model and helpers
    // ==================================================================

    // Inputs settle at the falling edge, so the rising edge sees the transfer
    always @(posedge clk) begin
        if (rst_n && mem_req_valid && mem_req_ready) begin
            seen_q.push_back({mem_req, mem_qos});
        end
    end

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    function automatic memory_req_t random_req(input logic [`MEM_ID_W-1:0] id);
        memory_req_t r;
        r.addr  = $urandom;
        r.wdata = $urandom;
        r.be    = 4'hf;
        r.we    = 1'($urandom);
        r.id    = id;
        return r;
    endfunction

    // Called on a falling edge, returns on the falling edge after the last transfer
    task automatic offer_pair(input logic use_i, input logic use_d,
                              input memory_req_t ireq, input qos_config_t iq,
                              input memory_req_t dreq, input qos_config_t dq);
        logic i_pend;
        logic d_pend;
        logic i_acc;
        logic d_acc;
        int   waited;
        i_pend = use_i;
        d_pend = use_d;
        waited = 0;
        icache_req_valid = use_i;
        icache_req       = ireq;
        icache_qos       = iq;
        dcache_req_valid = use_d;
        dcache_req       = dreq;
        dcache_qos       = dq;
        while ((i_pend || d_pend) && waited < MAX_WAIT) begin
            @(posedge clk);
            i_acc = i_pend && icache_req_ready;
            d_acc = d_pend && dcache_req_ready;
            @(negedge clk);
            if (i_acc) begin
                i_pend = 1'b0;
                icache_req_valid = 1'b0;
            end
            if (d_acc) begin
                d_pend = 1'b0;
                dcache_req_valid = 1'b0;
            end
            waited++;
        end
        if (i_pend || d_pend) begin
            error_count++;
            $display("Error: a cache request was never accepted");
            icache_req_valid = 1'b0;
            dcache_req_valid = 1'b0;
        end
    endtask

    // Next request accepted by memory must match
    task automatic expect_mem(input string tag, input memory_req_t req,
                              input qos_config_t qos);
        arb_req_t got;
        int       waited;
        waited = 0;
        while (seen_q.size() == 0 && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
        end
        check_count++;
        if (seen_q.size() == 0) begin
            error_count++;
            $display("Error: no memory request arrived for %s", tag);
        end else begin
            got = seen_q.pop_front();
            if (got.req !== req || got.qos !== qos) begin
                report_mismatch($sformatf("%s: memory got %h/%h, expected %h/%h",
                                          tag, got.req, got.qos, req, qos));
            end
        end
    endtask

    // ==================================================================
    // Tests
    // ==================================================================

    task automatic test_reset();
        check_count++;
        if (mem_req_valid !== 1'b0 || icache_rsp_valid !== 1'b0 ||
            dcache_rsp_valid !== 1'b0) begin
            report_mismatch("valid output high after reset");
        end
        if (icache_req_ready !== 1'b1 || dcache_req_ready !== 1'b1 ||
            mem_rsp_ready !== 1'b1) begin
            report_mismatch("ready output low after reset");
        end
    endtask

    task automatic test_single();
        memory_req_t r;
        qos_config_t q;
        r = random_req(4'd0);
        q = '{qos_level: 3'd3, urgent: 1'b1};
        qos_enable = 1'b1;
        offer_pair(1'b1, 1'b0, r, q, '0, '0);
        // One cycle after acceptance the buffer drives memory
        check_count++;
        if (mem_req_valid !== 1'b1 || mem_req !== r || mem_qos !== q) begin
            report_mismatch("single request not on memory side one cycle later");
        end
        expect_mem("single", r, q);
        mem_rsp       = '{rdata: $urandom, id: 4'd0, err: 1'b0};
        mem_rsp_valid = 1'b1;
        @(posedge clk);
        check_count++;
        if (icache_rsp_valid !== 1'b1 || dcache_rsp_valid !== 1'b0 ||
            cache_rsp !== mem_rsp || mem_rsp_ready !== 1'b1) begin
            report_mismatch("ID 0 response not routed to icache only");
        end
        @(negedge clk);
        mem_rsp_valid = 1'b0;
    endtask

    // Both caches at once, winner first on the memory side
    task automatic contend(input string tag, input qos_config_t iq,
                           input qos_config_t dq, input logic icache_wins,
                           input logic zero_qos);
        memory_req_t ir;
        memory_req_t dr;
        qos_config_t iexp;
        qos_config_t dexp;
        ir   = random_req(4'd0);
        dr   = random_req(4'd7);
        iexp = zero_qos ? '0 : iq;
        dexp = zero_qos ? '0 : dq;
        offer_pair(1'b1, 1'b1, ir, iq, dr, dq);
        if (icache_wins) begin
            expect_mem({tag, " first"}, ir, iexp);
            expect_mem({tag, " second"}, dr, dexp);
        end else begin
            expect_mem({tag, " first"}, dr, dexp);
            expect_mem({tag, " second"}, ir, iexp);
        end
    endtask

    task automatic test_qos();
        qos_enable = 1'b1;
        contend("dcache level higher", '{3'd2, 1'b0}, '{3'd5, 1'b0}, 1'b0, 1'b0);
        contend("tie icache urgent", '{3'd4, 1'b1}, '{3'd4, 1'b0}, 1'b1, 1'b0);
        contend("tie both urgent", '{3'd4, 1'b1}, '{3'd4, 1'b1}, 1'b0, 1'b0);
        qos_enable = 1'b0;
        contend("qos disabled", '{3'd1, 1'b0}, '{3'd7, 1'b1}, 1'b1, 1'b1);
    endtask

    task automatic test_backpressure();
        memory_req_t r [0:2];
        qos_config_t q;
        q = '{qos_level: 3'd1, urgent: 1'b0};
        qos_enable    = 1'b1;
        mem_req_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            r[i] = random_req(4'(i + 1));
        end
        offer_pair(1'b0, 1'b1, '0, '0, r[0], q);
        offer_pair(1'b0, 1'b1, '0, '0, r[1], q);
        // Third request must wait while the buffer is full
        dcache_req_valid = 1'b1;
        dcache_req       = r[2];
        dcache_qos       = q;
        repeat (4) begin
            @(posedge clk);
            check_count++;
            if (dcache_req_ready !== 1'b0) begin
                report_mismatch("dcache ready high with buffer full");
            end
        end
        @(negedge clk);
        // Oldest request still waits at the memory port
        check_count++;
        if (mem_req_valid !== 1'b1 || mem_req !== r[0] || mem_qos !== q) begin
            report_mismatch("buffer head not held while memory is stalled");
        end
        mem_req_ready = 1'b1;
        offer_pair(1'b0, 1'b1, '0, '0, r[2], q);
        for (int i = 0; i < 3; i++) begin
            expect_mem($sformatf("backpressure %0d", i), r[i], q);
        end
    endtask

    task automatic test_routing();
        mem_rsp          = '{rdata: $urandom, id: 4'd5, err: 1'b1};
        mem_rsp_valid    = 1'b1;
        dcache_rsp_ready = 1'b0;
        @(posedge clk);
        check_count++;
        if (dcache_rsp_valid !== 1'b1 || icache_rsp_valid !== 1'b0 ||
            cache_rsp !== mem_rsp) begin
            report_mismatch("ID 5 response not routed to dcache only");
        end
        if (mem_rsp_ready !== 1'b0) begin
            report_mismatch("mem_rsp_ready high while dcache not ready");
        end
        @(negedge clk);
        dcache_rsp_ready = 1'b1;
        @(posedge clk);
        check_count++;
        if (mem_rsp_ready !== 1'b1 || dcache_rsp_valid !== 1'b1) begin
            report_mismatch("response not delivered after dcache ready");
        end
        @(negedge clk);
        mem_rsp_valid = 1'b0;
    endtask

    // ==================================================================
    // Sequence and watchdog
    // ==================================================================

    initial begin
        void'($urandom(32'hbdac_042b));
        icache_req_valid = 1'b0;
        dcache_req_valid = 1'b0;
        icache_req       = '0;
        dcache_req       = '0;
        icache_qos       = '0;
        dcache_qos       = '0;
        icache_rsp_ready = 1'b1;
        dcache_rsp_ready = 1'b1;
        qos_enable       = 1'b0;
        mem_req_ready    = 1'b1;
        mem_rsp_valid    = 1'b0;
        mem_rsp          = '0;
        @(posedge rst_n);
        @(negedge clk);
        test_reset();
        test_single();
        test_qos();
        test_backpressure();
        test_routing();
        repeat (2) @(negedge clk);
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule : mem_arb_tb

/* all.f */
+incdir+src
src/mem_arb_pkg.sv
src/qos_arbiter.sv
src/req_pipe_stage.sv
src/rsp_router.sv
src/mem_arb_top.sv
test/tb_clkgen.sv
test/mem_arb_asserts.sv
test/mem_arb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the memory arbiter testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module mem_arb_tb \
    -o Vmem_arb_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vmem_arb_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASS$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
